//--- source/bus_int_map_pkg.sv
// --------------------
// Board bus register map
// Settings and readback indices, field widths,
// reset values and the compat number
// --------------------
package bus_int_map_pkg;

   // Register index widths, one word per index
   localparam int SR_AWIDTH = 8;
   localparam int RB_AWIDTH = 8;

   // --------------------
   // Settings space (writes)
   localparam logic [SR_AWIDTH-1:0] SR_LEDS       = 8'd0;
   localparam logic [SR_AWIDTH-1:0] SR_SW_RST     = 8'd1;
   localparam logic [SR_AWIDTH-1:0] SR_CLOCK_CTRL = 8'd2;
   localparam logic [SR_AWIDTH-1:0] SR_REF_FREQ   = 8'd4;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL0 = 8'd8;
   localparam logic [SR_AWIDTH-1:0] SR_SFPP_CTRL1 = 8'd9;

   // --------------------
   // Readback space (reads)
   localparam logic [RB_AWIDTH-1:0] RB_COUNTER      = 8'd0;
   localparam logic [RB_AWIDTH-1:0] RB_CLK_STATUS   = 8'd3;
   localparam logic [RB_AWIDTH-1:0] RB_COMPAT_NUM   = 8'd6;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS0 = 8'd8;
   localparam logic [RB_AWIDTH-1:0] RB_SFPP_STATUS1 = 8'd9;

   // Field widths of the settings registers
   localparam int LEDS_W       = 2;
   localparam int SW_RST_W     = 4;
   localparam int CLOCK_CTRL_W = 8;
   localparam int SFPP_CTRL_W  = 2;

   // Bit 6 set keeps the GPSDO on out of reset
   localparam logic [CLOCK_CTRL_W-1:0] CLOCK_CTRL_RESET = 8'h40;
   // 10 MHz reference by default
   localparam logic [31:0] REF_FREQ_RESET = 32'd10_000_000;

   localparam logic [15:0] COMPAT_MAJOR = 16'h0024;
   localparam logic [15:0] COMPAT_MINOR = 16'h0000;

   localparam int PHY_STATUS_W = 16;
   localparam int SYNC_STAGES  = 2;

endpackage

//--- source/bus_int_types_pkg.sv
// --------------------
// Board bus types
// Register words, bus structs, SFP+ pin group
// and the AXI4-Lite channel states
// --------------------
package bus_int_types_pkg;

   // One register word
   typedef logic [31:0] reg_data_t;

   // Register index, byte address bits 9:2
   typedef logic [bus_int_map_pkg::SR_AWIDTH-1:0] reg_index_t;

   // PHY status word from each SFP+ cage
   typedef logic [bus_int_map_pkg::PHY_STATUS_W-1:0] phy_status_t;

   // --------------------
   // Settings bus, one strobe per write
   typedef struct packed {
      logic       stb;
      reg_index_t addr;
      reg_data_t  data;
   } set_bus_t;

   // Readback request, strobe marks the read
   typedef struct packed {
      logic                                 stb;
      logic [bus_int_map_pkg::RB_AWIDTH-1:0] addr;
   } rb_req_t;

   // SFP+ module status pins, packed in readback order
   typedef struct packed {
      logic mod_abs;
      logic tx_fault;
      logic rx_los;
   } sfpp_pins_t;

   // Channel state, shared by write and read sides
   typedef enum logic {
      IDLE,
      RESP
   } axil_state_t;

endpackage

//--- source/axil_settings_bridge.sv
// --------------------
// AXI4-Lite slave for the register block
// Writes become settings strobes, reads become
// readback strobes with one cycle of latency
// --------------------
`timescale 1ns/1ps

module axil_settings_bridge (
   input  logic                         clk,
   input  logic                         i_reset,
   // Write address and data
   input  logic                         i_awvalid,
   output logic                         o_awready,
   input  logic [11:0]                  i_awaddr,
   input  logic                         i_wvalid,
   output logic                         o_wready,
   input  bus_int_types_pkg::reg_data_t i_wdata,
   // Write response
   output logic                         o_bvalid,
   input  logic                         i_bready,
   output logic [1:0]                   o_bresp,
   // Read address and data
   input  logic                         i_arvalid,
   output logic                         o_arready,
   input  logic [11:0]                  i_araddr,
   output logic                         o_rvalid,
   input  logic                         i_rready,
   output bus_int_types_pkg::reg_data_t o_rdata,
   output logic [1:0]                   o_rresp,
   // Register side
   output bus_int_types_pkg::set_bus_t  o_set,
   output bus_int_types_pkg::rb_req_t   o_rb,
   input  bus_int_types_pkg::reg_data_t i_rb_data
);

   bus_int_types_pkg::axil_state_t wr_state;
   bus_int_types_pkg::axil_state_t rd_state;
   logic                           wr_hs;
   logic                           rd_hs;
   bus_int_types_pkg::reg_data_t   rdata_q;

   // --------------------
   // Write channel
   // Address and data are taken together, never one alone
   assign o_awready = (wr_state == bus_int_types_pkg::IDLE) && i_awvalid && i_wvalid;
   assign o_wready  = o_awready;
   assign wr_hs     = o_awready;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         wr_state  <= bus_int_types_pkg::IDLE;
         o_set.stb <= 1'b0;
      end else begin
         o_set.stb <= wr_hs;
         if (wr_hs) begin
            wr_state <= bus_int_types_pkg::RESP;
         end else if (i_bready) begin
            wr_state <= bus_int_types_pkg::IDLE;
         end
      end
   end

   // Payload of the settings bus
   always_ff @(posedge clk) begin
      if (wr_hs) begin
         o_set.addr <= i_awaddr[9:2];
         o_set.data <= i_wdata;
      end
   end

   assign o_bvalid = (wr_state == bus_int_types_pkg::RESP);
   assign o_bresp  = 2'b00;

   // --------------------
   // Read channel
   assign o_arready = (rd_state == bus_int_types_pkg::IDLE);
   assign rd_hs     = o_arready && i_arvalid;

   // Strobe goes out on the handshake cycle itself
   assign o_rb.stb  = rd_hs;
   assign o_rb.addr = i_araddr[9:2];

   always_ff @(posedge clk) begin
      if (i_reset) begin
         rd_state <= bus_int_types_pkg::IDLE;
      end else if (rd_hs) begin
         rd_state <= bus_int_types_pkg::RESP;
      end else if (i_rready) begin
         rd_state <= bus_int_types_pkg::IDLE;
      end
   end

   // Word is held until the master takes it
   always_ff @(posedge clk) begin
      if (rd_hs) begin
         rdata_q <= i_rb_data;
      end
   end

   assign o_rvalid = (rd_state == bus_int_types_pkg::RESP);
   assign o_rdata  = rdata_q;
   assign o_rresp  = 2'b00;

endmodule

//--- source/settings_regs.sv
// --------------------
// Settings registers of the board bus
// LEDs, soft resets, clock control, reference
// frequency and SFP+ rate-select drives
// --------------------
`timescale 1ns/1ps

module settings_regs (
   input  logic                                         clk,
   input  logic                                         i_reset,
   input  bus_int_types_pkg::set_bus_t                  i_set,
   output logic [bus_int_map_pkg::LEDS_W-1:0]           o_leds,
   output logic [bus_int_map_pkg::SW_RST_W-1:0]         o_sw_rst,
   output logic [bus_int_map_pkg::CLOCK_CTRL_W-1:0]     o_clock_control,
   output bus_int_types_pkg::reg_data_t                 o_ref_freq,
   output logic                                         o_ref_freq_changed,
   output logic [bus_int_map_pkg::SFPP_CTRL_W-1:0]      o_sfpp0_rs_drive,
   output logic [bus_int_map_pkg::SFPP_CTRL_W-1:0]      o_sfpp1_rs_drive
);

   // SW_RST bits
   // [0] PHY, [1] radio domain, [2] radio PLL, [3] IDELAYCTRL
   //
   // RS drive bit high pulls the open-drain RS pin low,
   // bit 0 for RS0 and bit 1 for RS1

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_leds             <= '0;
         o_sw_rst           <= '0;
         o_clock_control    <= bus_int_map_pkg::CLOCK_CTRL_RESET;
         o_ref_freq         <= bus_int_map_pkg::REF_FREQ_RESET;
         o_ref_freq_changed <= 1'b0;
         o_sfpp0_rs_drive   <= '0;
         o_sfpp1_rs_drive   <= '0;
      end else begin
         o_ref_freq_changed <= 1'b0;
         if (i_set.stb) begin
            // Single decode of the index, unmapped ones fall through
            case (i_set.addr)
               bus_int_map_pkg::SR_LEDS: begin
                  o_leds <= i_set.data[bus_int_map_pkg::LEDS_W-1:0];
               end
               bus_int_map_pkg::SR_SW_RST: begin
                  o_sw_rst <= i_set.data[bus_int_map_pkg::SW_RST_W-1:0];
               end
               bus_int_map_pkg::SR_CLOCK_CTRL: begin
                  o_clock_control <= i_set.data[bus_int_map_pkg::CLOCK_CTRL_W-1:0];
               end
               bus_int_map_pkg::SR_REF_FREQ: begin
                  o_ref_freq         <= i_set.data;
                  o_ref_freq_changed <= 1'b1;
               end
               bus_int_map_pkg::SR_SFPP_CTRL0: begin
                  o_sfpp0_rs_drive <= i_set.data[bus_int_map_pkg::SFPP_CTRL_W-1:0];
               end
               bus_int_map_pkg::SR_SFPP_CTRL1: begin
                  o_sfpp1_rs_drive <= i_set.data[bus_int_map_pkg::SFPP_CTRL_W-1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

//--- source/sfpp_status_monitor.sv
// --------------------
// SFP+ cage status monitor
// Synchronizes pins and PHY status, keeps
// sticky change flags cleared on read
// --------------------
`timescale 1ns/1ps

module sfpp_status_monitor (
   input  logic                           clk,
   input  logic                           i_reset,
   input  bus_int_types_pkg::sfpp_pins_t  i_pins,
   input  bus_int_types_pkg::phy_status_t i_phy_status,
   input  logic                           i_clear,
   output bus_int_types_pkg::reg_data_t   o_status
);

   localparam int LAST = bus_int_map_pkg::SYNC_STAGES - 1;

   bus_int_types_pkg::sfpp_pins_t  pin_sync [bus_int_map_pkg::SYNC_STAGES];
   bus_int_types_pkg::phy_status_t phy_sync [bus_int_map_pkg::SYNC_STAGES];
   bus_int_types_pkg::sfpp_pins_t  pin_prev;
   bus_int_types_pkg::sfpp_pins_t  pin_chgd;

   // All inputs are asynchronous, bit by bit
   always_ff @(posedge clk) begin
      pin_sync[0] <= i_pins;
      phy_sync[0] <= i_phy_status;
      for (int i = 1; i < bus_int_map_pkg::SYNC_STAGES; i++) begin
         pin_sync[i] <= pin_sync[i-1];
         phy_sync[i] <= phy_sync[i-1];
      end
      pin_prev <= pin_sync[LAST];
   end

   // Sticky flags, one per pin
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         pin_chgd <= '0;
      end else begin
         pin_chgd <= pin_chgd | (pin_sync[LAST] ^ pin_prev);
      end
   end

   assign o_status = {phy_sync[LAST], 10'b0, pin_chgd, pin_sync[LAST]};

endmodule

//--- source/readback_mux.sv
// --------------------
// Readback select for the board bus
// Free-running counter, word select by index
// and clear-on-read of the SFP+ status
// --------------------
`timescale 1ns/1ps

module readback_mux (
   input  logic                         clk,
   input  logic                         i_reset,
   input  bus_int_types_pkg::rb_req_t   i_rb,
   input  logic [7:0]                   i_clock_status,
   input  bus_int_types_pkg::reg_data_t i_sfpp0_status,
   input  bus_int_types_pkg::reg_data_t i_sfpp1_status,
   output bus_int_types_pkg::reg_data_t o_rb_data,
   output logic                         o_clear_sfpp0,
   output logic                         o_clear_sfpp1
);

   bus_int_types_pkg::reg_data_t counter;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         counter <= '0;
      end else begin
         counter <= counter + 32'd1;
      end
   end

   always_comb begin
      case (i_rb.addr)
         bus_int_map_pkg::RB_COUNTER:      o_rb_data = counter;
         bus_int_map_pkg::RB_CLK_STATUS:   o_rb_data = {24'b0, i_clock_status};
         bus_int_map_pkg::RB_COMPAT_NUM:   o_rb_data = {bus_int_map_pkg::COMPAT_MAJOR,
                                                        bus_int_map_pkg::COMPAT_MINOR};
         bus_int_map_pkg::RB_SFPP_STATUS0: o_rb_data = i_sfpp0_status;
         bus_int_map_pkg::RB_SFPP_STATUS1: o_rb_data = i_sfpp1_status;
         default:                          o_rb_data = '0;
      endcase
   end

   // Flags drop on the same edge the word is captured
   assign o_clear_sfpp0 = i_rb.stb && (i_rb.addr == bus_int_map_pkg::RB_SFPP_STATUS0);
   assign o_clear_sfpp1 = i_rb.stb && (i_rb.addr == bus_int_map_pkg::RB_SFPP_STATUS1);

endmodule

//--- source/bus_int.sv
// --------------------
// Board bus register block
// AXI4-Lite access to settings, readback and
// SFP+ status monitoring
// --------------------
`timescale 1ns/1ps

module bus_int (
   input  logic                                     clk,
   input  logic                                     i_reset,
   input  logic                                     i_awvalid,
   output logic                                     o_awready,
   input  logic [11:0]                              i_awaddr,
   input  logic                                     i_wvalid,
   output logic                                     o_wready,
   input  bus_int_types_pkg::reg_data_t             i_wdata,
   output logic                                     o_bvalid,
   input  logic                                     i_bready,
   output logic [1:0]                               o_bresp,
   input  logic                                     i_arvalid,
   output logic                                     o_arready,
   input  logic [11:0]                              i_araddr,
   output logic                                     o_rvalid,
   input  logic                                     i_rready,
   output bus_int_types_pkg::reg_data_t             o_rdata,
   output logic [1:0]                               o_rresp,
   input  logic [7:0]                               i_clock_status,
   input  bus_int_types_pkg::sfpp_pins_t            i_sfpp0_pins,
   input  bus_int_types_pkg::sfpp_pins_t            i_sfpp1_pins,
   input  bus_int_types_pkg::phy_status_t           i_sfpp0_phy_status,
   input  bus_int_types_pkg::phy_status_t           i_sfpp1_phy_status,
   output logic [bus_int_map_pkg::LEDS_W-1:0]       o_leds,
   output logic [bus_int_map_pkg::SW_RST_W-1:0]     o_sw_rst,
   output logic [bus_int_map_pkg::CLOCK_CTRL_W-1:0] o_clock_control,
   output bus_int_types_pkg::reg_data_t             o_ref_freq,
   output logic                                     o_ref_freq_changed,
   output logic [bus_int_map_pkg::SFPP_CTRL_W-1:0]  o_sfpp0_rs_drive,
   output logic [bus_int_map_pkg::SFPP_CTRL_W-1:0]  o_sfpp1_rs_drive
);

   bus_int_types_pkg::set_bus_t  set_bus;
   bus_int_types_pkg::rb_req_t   rb_req;
   bus_int_types_pkg::reg_data_t rb_data;
   bus_int_types_pkg::reg_data_t sfpp0_status;
   bus_int_types_pkg::reg_data_t sfpp1_status;
   logic                         clear_sfpp0;
   logic                         clear_sfpp1;

   axil_settings_bridge u_bridge (
      .clk(clk), .i_reset(i_reset),
      .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
      .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
      .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
      .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
      .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
      .o_set(set_bus), .o_rb(rb_req), .i_rb_data(rb_data)
   );

   settings_regs u_settings (
      .clk(clk), .i_reset(i_reset), .i_set(set_bus),
      .o_leds(o_leds), .o_sw_rst(o_sw_rst), .o_clock_control(o_clock_control),
      .o_ref_freq(o_ref_freq), .o_ref_freq_changed(o_ref_freq_changed),
      .o_sfpp0_rs_drive(o_sfpp0_rs_drive), .o_sfpp1_rs_drive(o_sfpp1_rs_drive)
   );

   readback_mux u_readback (
      .clk(clk), .i_reset(i_reset), .i_rb(rb_req), .i_clock_status(i_clock_status),
      .i_sfpp0_status(sfpp0_status), .i_sfpp1_status(sfpp1_status), .o_rb_data(rb_data),
      .o_clear_sfpp0(clear_sfpp0), .o_clear_sfpp1(clear_sfpp1)
   );

   // One monitor per cage
   sfpp_status_monitor u_sfpp0_mon (
      .clk(clk), .i_reset(i_reset), .i_pins(i_sfpp0_pins),
      .i_phy_status(i_sfpp0_phy_status), .i_clear(clear_sfpp0), .o_status(sfpp0_status)
   );

   sfpp_status_monitor u_sfpp1_mon (
      .clk(clk), .i_reset(i_reset), .i_pins(i_sfpp1_pins),
      .i_phy_status(i_sfpp1_phy_status), .i_clear(clear_sfpp1), .o_status(sfpp1_status)
   );

endmodule

//--- verif/bus_int_tb_tasks.svh
// --------------------
// AXI4-Lite master tasks and error counting
// for the register block testbench
// --------------------
`ifndef BUS_INT_TB_TASKS_SVH
`define BUS_INT_TB_TASKS_SVH

int errors     = 0;
int tests_run  = 0;
int tests_bad  = 0;
int test_start = 0;

function automatic void mismatch(input string msg);
   $display("Mismatch at %0t ns: %s", $time, msg);
   errors++;
endfunction

function automatic void complain(input string msg);
   $display("At %0t ns: %s", $time, msg);
   errors++;
endfunction

// One summary line per test
task automatic end_test(input string name);
   int found;
   found = errors - test_start;
   tests_run++;
   if (found != 0)
      tests_bad++;
   $display("%-18s %0d error(s)", name, found);
   test_start = errors;
endtask

// --------------------
// Called 1 ns after a rising edge, returns at the same point of a later cycle
task automatic axil_write(input logic [7:0] idx, input logic [31:0] data, input int stall);
   int n;
   i_awaddr  = {2'b00, idx, 2'b00};
   i_wdata   = data;
   i_awvalid = 1'b1;
   i_wvalid  = 1'b1;
   n = 0;
   @(negedge clk);
   while (!(o_awready && o_wready) && n < 20) begin
      n++;
      @(negedge clk);
   end
   if (!(o_awready && o_wready))
      complain("write address and data were never accepted");
   @(posedge clk);
   #1;
   // A second write offered while the response waits must be refused
   i_wdata   = ~data;
   i_awvalid = (stall > 0);
   i_wvalid  = (stall > 0);
   if (!o_bvalid)
      complain("write response valid did not rise after the handshake");
   assert (o_bresp == 2'b00) else mismatch("write response is not OKAY");
   repeat (stall) begin
      @(posedge clk);
      #1;
   end
   i_awvalid = 1'b0;
   i_wvalid  = 1'b0;
   i_bready  = 1'b1;
   @(posedge clk);
   #1;
   i_bready = 1'b0;
endtask

task automatic axil_read(input logic [7:0] idx, input int stall, output logic [31:0] data);
   int n;
   i_araddr  = {2'b00, idx, 2'b00};
   i_arvalid = 1'b1;
   n = 0;
   @(negedge clk);
   while (!o_arready && n < 20) begin
      n++;
      @(negedge clk);
   end
   if (!o_arready)
      complain("read address was never accepted");
   @(posedge clk);
   #1;
   // Counter read held back behind the pending response
   i_araddr  = 12'h000;
   i_arvalid = (stall > 0);
   if (!o_rvalid)
      complain("read data valid did not rise one cycle after the address");
   assert (o_rresp == 2'b00) else mismatch("read response is not OKAY");
   data = o_rdata;
   repeat (stall) begin
      @(posedge clk);
      #1;
   end
   i_arvalid = 1'b0;
   i_rready  = 1'b1;
   @(posedge clk);
   #1;
   i_rready = 1'b0;
endtask

`endif

//--- verif/bus_int_tb.sv
// --------------------
// Testbench for the board bus register block
// Settings, readback, SFP+ status and back-pressure
// --------------------
`timescale 1ns/1ps

module bus_int_tb;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int CLK_PERIOD      = 20;
   localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

   logic                           clk = 1'b0;
   logic                           i_reset;
   logic                           i_awvalid, o_awready, i_wvalid, o_wready;
   logic [11:0]                    i_awaddr, i_araddr;
   logic [31:0]                    i_wdata, o_rdata, o_ref_freq;
   logic                           o_bvalid, i_bready, i_arvalid, o_arready;
   logic                           o_rvalid, i_rready, o_ref_freq_changed;
   logic [1:0]                     o_bresp, o_rresp, o_leds;
   logic [1:0]                     o_sfpp0_rs_drive, o_sfpp1_rs_drive;
   logic [3:0]                     o_sw_rst;
   logic [7:0]                     i_clock_status, o_clock_control;
   bus_int_types_pkg::sfpp_pins_t  i_sfpp0_pins, i_sfpp1_pins;
   bus_int_types_pkg::phy_status_t i_sfpp0_phy_status, i_sfpp1_phy_status;
   int                             changed_pulses = 0;

   bus_int u_dut (.*);

   always #10 clk = ~clk;

   always @(negedge clk) begin
      if (o_ref_freq_changed)
         changed_pulses++;
   end

`include "bus_int_tb_tasks.svh"

   // --------------------
   // Response channel rules
   assert property (@(posedge clk) disable iff (i_reset) o_bvalid && !i_bready |=> o_bvalid)
      else complain("write response valid dropped before bready");
   assert property (@(posedge clk) disable iff (i_reset)
                    o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata))
      else mismatch("read data or rvalid changed while rready was low");
   assert property (@(posedge clk) disable iff (i_reset) o_bvalid |-> !o_awready)
      else complain("new write accepted while a write response was pending");
   assert property (@(posedge clk) disable iff (i_reset) o_rvalid |-> !o_arready)
      else complain("new read accepted while read data was pending");

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      logic [31:0] rnd;
      logic [31:0] got;
      logic [31:0] first;
      logic [49:0] snap;
      logic [2:0]  mask0;
      logic [2:0]  mask1;
      int          pulses_before;
      int          stall;
      bus_int_types_pkg::sfpp_pins_t new0;
      bus_int_types_pkg::sfpp_pins_t new1;
      void'($urandom(58));
      i_reset   = 1'b1;
      i_awvalid = 1'b0;
      i_wvalid  = 1'b0;
      i_awaddr  = '0;
      i_wdata   = '0;
      i_bready  = 1'b0;
      i_arvalid = 1'b0;
      i_araddr  = '0;
      i_rready  = 1'b0;
      i_clock_status     = '0;
      i_sfpp0_pins       = '0;
      i_sfpp1_pins       = '0;
      i_sfpp0_phy_status = '0;
      i_sfpp1_phy_status = '0;
      repeat (8) @(posedge clk);
      #1;
      i_reset = 1'b0;
      @(posedge clk);
      #1;

      // 1 Reset values
      assert (o_leds == 2'd0 && o_sw_rst == 4'd0) else mismatch("LEDs or soft resets");
      assert (o_sfpp0_rs_drive == 2'd0 && o_sfpp1_rs_drive == 2'd0) else mismatch("RS drives");
      assert (o_clock_control == 8'h40) else mismatch("clock control reset value");
      assert (o_ref_freq == 32'd10_000_000) else mismatch("reference frequency reset value");
      assert (!o_ref_freq_changed) else mismatch("reference frequency changed pulse");
      assert (!o_bvalid && !o_rvalid) else mismatch("response valids after reset");
      assert (!o_awready && !o_wready && o_arready) else mismatch("ready outputs after reset");
      end_test("reset values");

      // 2 Settings writes, truncated to each field
      rnd = $urandom();
      axil_write(bus_int_map_pkg::SR_LEDS, rnd, 0);
      assert (o_leds == rnd[1:0]) else mismatch("LEDs after write");
      rnd = $urandom();
      axil_write(bus_int_map_pkg::SR_SW_RST, rnd, 0);
      assert (o_sw_rst == rnd[3:0]) else mismatch("soft resets after write");
      rnd = $urandom();
      axil_write(bus_int_map_pkg::SR_CLOCK_CTRL, rnd, 0);
      assert (o_clock_control == rnd[7:0]) else mismatch("clock control after write");
      rnd = $urandom();
      pulses_before = changed_pulses;
      axil_write(bus_int_map_pkg::SR_REF_FREQ, rnd, 0);
      assert (o_ref_freq == rnd) else mismatch("reference frequency after write");
      rnd = $urandom();
      axil_write(bus_int_map_pkg::SR_SFPP_CTRL0, rnd, 0);
      assert (o_sfpp0_rs_drive == rnd[1:0]) else mismatch("SFP+ 0 RS drive after write");
      rnd = $urandom();
      axil_write(bus_int_map_pkg::SR_SFPP_CTRL1, rnd, 0);
      assert (o_sfpp1_rs_drive == rnd[1:0]) else mismatch("SFP+ 1 RS drive after write");
      assert (changed_pulses - pulses_before == 1) else mismatch("changed pulse length");
      snap = {o_leds, o_sw_rst, o_clock_control, o_ref_freq, o_sfpp0_rs_drive, o_sfpp1_rs_drive};
      axil_write(8'd5, $urandom(), 0);
      assert (snap == {o_leds, o_sw_rst, o_clock_control, o_ref_freq, o_sfpp0_rs_drive,
                       o_sfpp1_rs_drive}) else mismatch("unmapped write changed an output");
      end_test("settings writes");

      // 3 Fixed readback words
      rnd = $urandom();
      i_clock_status = rnd[7:0];
      axil_read(bus_int_map_pkg::RB_CLK_STATUS, 0, got);
      assert (got == {24'h0, rnd[7:0]}) else mismatch("clock status readback");
      axil_read(bus_int_map_pkg::RB_COMPAT_NUM, 0, got);
      assert (got == 32'h0024_0000) else mismatch("compat number readback");
      axil_read(8'd5, 0, got);
      assert (got == 32'h0) else mismatch("unmapped readback");
      end_test("fixed readback");

      // 4 SFP+ status, flags cleared by the first read
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS0, 0, got);
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS1, 0, got);
      rnd = $urandom();
      mask0 = (rnd[2:0] == 3'b000) ? 3'b101 : rnd[2:0];
      mask1 = (rnd[5:3] == 3'b000) ? 3'b010 : rnd[5:3];
      new0 = i_sfpp0_pins ^ mask0;
      new1 = i_sfpp1_pins ^ mask1;
      i_sfpp0_pins       = new0;
      i_sfpp1_pins       = new1;
      i_sfpp0_phy_status = rnd[31:16];
      i_sfpp1_phy_status = rnd[15:0];
      repeat (5) @(posedge clk);
      #1;
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS0, 0, got);
      assert (got == {rnd[31:16], 10'b0, mask0, new0}) else mismatch("SFP+ 0 first read");
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS0, 0, got);
      assert (got == {rnd[31:16], 10'b0, 3'b000, new0}) else mismatch("SFP+ 0 second read");
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS1, 0, got);
      assert (got == {rnd[15:0], 10'b0, mask1, new1}) else mismatch("SFP+ 1 first read");
      axil_read(bus_int_map_pkg::RB_SFPP_STATUS1, 0, got);
      assert (got == {rnd[15:0], 10'b0, 3'b000, new1}) else mismatch("SFP+ 1 second read");
      end_test("sfp+ status");

      // 5 Counter
      axil_read(bus_int_map_pkg::RB_COUNTER, 0, first);
      axil_read(bus_int_map_pkg::RB_COUNTER, 0, got);
      assert (got > first) else mismatch("counter did not increase");
      end_test("counter");

      // 6 Back-pressure on both response channels
      rnd = $urandom();
      stall = 1 + int'(rnd[2:0]);
      axil_write(bus_int_map_pkg::SR_LEDS, rnd, stall);
      assert (o_leds == rnd[1:0]) else mismatch("LEDs after a held write response");
      stall = 1 + int'(rnd[5:3]);
      axil_read(bus_int_map_pkg::RB_COMPAT_NUM, stall, got);
      assert (got == 32'h0024_0000) else mismatch("compat number after held read data");
      end_test("back-pressure");

      $display("Tests run %0d, with errors %0d, errors %0d", tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- list.f
+incdir+verif
source/bus_int_map_pkg.sv
source/bus_int_types_pkg.sv
source/axil_settings_bridge.sv
source/settings_regs.sv
source/sfpp_status_monitor.sv
source/readback_mux.sv
source/bus_int.sv
verif/bus_int_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := bus_int_tb
FILELIST  := list.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o sim_$(TOP)
	./$(OBJDIR)/sim_$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
